//--- all.f
+incdir+tests
src/eth_rx_pkg.sv
src/eth_reg_pkg.sv
src/crc32_byte.sv
src/gmii_rx_framer.sv
src/rx_word_fifo.sv
src/rx_status_regs.sv
src/eth_rx_top.sv
tests/tb_eth_rx.sv

//--- tests/tb_eth_rx_frames.svh
// Frame table for the GMII receive testbench
// Entry type, pre-frame actions and one row per frame

typedef enum logic [1:0] {
    ACT_NONE,
    ACT_FLUSH,   // Flush word FIFO before the frame
    ACT_CLEAR    // Clear counters before the frame
} frame_act_e;

// One row of stimulus and expected outcome
typedef struct packed {
    frame_act_e  act;
    logic [11:0] plen;      // Payload bytes, FCS not included
    logic [3:0]  npre;      // 0x55 bytes before the SFD
    byte_t       sfd;       // Byte sent in the SFD slot
    logic        bad_fcs;   // Flip one FCS bit
    logic        err_en;    // Pulse RxErr once
    logic [11:0] err_at;    // Frame cycle of the pulse, 0 = first preamble byte
    logic        exp_good;  // Frame should count as good
} frame_entry_t;

localparam int NUM_FRAMES = 13;

frame_entry_t frames [NUM_FRAMES];

task automatic load_frames();
    //             act        plen     pre   sfd    fcs   err   at      good
    frames[0]  = '{ACT_NONE,  12'd46,  4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};  // Even length
    frames[1]  = '{ACT_NONE,  12'd61,  4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};  // Odd length
    frames[2]  = '{ACT_NONE,  12'd1,   4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};  // Shortest
    frames[3]  = '{ACT_NONE,  12'd64,  4'd7, 8'hD5, 1'b1, 1'b0, 12'd0,  1'b0};  // Bad FCS
    frames[4]  = '{ACT_NONE,  12'd30,  4'd6, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b0};  // Short preamble
    frames[5]  = '{ACT_NONE,  12'd31,  4'd8, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b0};  // Long preamble
    frames[6]  = '{ACT_NONE,  12'd20,  4'd7, 8'hD4, 1'b0, 1'b0, 12'd0,  1'b0};  // Wrong SFD
    frames[7]  = '{ACT_NONE,  12'd40,  4'd7, 8'hD5, 1'b0, 1'b1, 12'd20, 1'b0};  // RxErr in payload
    frames[8]  = '{ACT_CLEAR, 12'd50,  4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};
    frames[9]  = '{ACT_NONE,  12'd600, 4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};  // Overfills FIFO
    frames[10] = '{ACT_NONE,  12'd33,  4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};  // Left unread
    frames[11] = '{ACT_FLUSH, 12'd18,  4'd7, 8'hD5, 1'b0, 1'b0, 12'd0,  1'b1};
    frames[12] = '{ACT_NONE,  12'd27,  4'd7, 8'hD5, 1'b0, 1'b1, 12'd3,  1'b0};  // RxErr in preamble
endtask

//--- tests/tb_eth_rx.sv
// Testbench for the GMII receive top level
// Clock, reset, LCG payloads, reference CRC, frame driver,
// word and register checks, cycle limit

`timescale 1ns/1ps

module tb_eth_rx;
    import eth_rx_pkg::*;
    import eth_reg_pkg::*;

    localparam int FIFO_WORDS = 256;   // Word FIFO capacity

    logic       RxClk;
    logic       rst_n;
    logic       RxValid;
    byte_t      RxD;
    logic       RxErr;
    logic       word_rd;
    word_t      word_dout;
    logic       word_empty;
    reg_addr_t  reg_raddr;
    reg_addr_t  reg_waddr;
    logic       reg_wen;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;
    rx_status_t status;
    logic       status_valid;

    byte_t       fbytes [0:1023];  // Bytes after SFD, FCS included
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          test_errs;        // Errors in the running test
    int          good_exp;
    int          bad_exp;
    int          drop_exp;

    `include "tb_eth_rx_frames.svh"

    eth_rx_top u_dut (.*);

    initial begin
        RxClk = 1'b0;
        forever #10 RxClk = ~RxClk;   // 20 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Reflected CRC-32 over the first n frame bytes, one bit at a time
    function automatic crc_t crc_calc(input int n);
        crc_t c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++)
            for (int b = 0; b < 8; b++)
                c = (c[0] ^ fbytes[i][b]) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        return c;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_status(input rx_status_t exp, input rx_status_t act);
        checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH t=%0t status exp=%h act=%h", $time, exp, act);
        end
    endtask

    task automatic check_word(input int idx, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH t=%0t word_dout[%0d] exp=%h act=%h", $time, idx, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH t=%0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic expect_empty(input string when);
        checks++;
        @(negedge RxClk);
        if (word_empty !== 1'b1) begin
            test_errs++;
            $display("ERROR t=%0t word FIFO not empty %s", $time, when);
        end
    endtask

    // --------------------------------------------------
    // Bus and frame helpers
    // --------------------------------------------------
    task automatic read_check(input reg_addr_t addr, input string name, input reg_data_t exp);
        @(posedge RxClk);
        reg_raddr <= addr;
        @(negedge RxClk);                  // Readback is combinational
        check_reg(name, exp, reg_rdata);
    endtask

    task automatic counters_check();
        read_check(RA_GOOD_CNT, "good_cnt", reg_data_t'(good_exp));
        read_check(RA_BAD_CNT, "bad_cnt", reg_data_t'(bad_exp));
        read_check(RA_DROP_CNT, "drop_cnt", reg_data_t'(drop_exp));
    endtask

    task automatic write_reg(input reg_addr_t addr);
        @(posedge RxClk);
        reg_waddr <= addr;
        reg_wdata <= 32'h1;                // Bit 0 qualifies the write
        reg_wen   <= 1'b1;
        @(posedge RxClk);
        reg_wen   <= 1'b0;
        @(posedge RxClk);                  // Flush or clear has landed
    endtask

    // Payload from the LCG, then FCS low byte first; returns bytes after SFD
    task automatic build_frame(input frame_entry_t f, output int n);
        crc_t fcs;
        n = f.plen;
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            fbytes[i] = lcg_state[23:16];
        end
        fcs = ~crc_calc(n);
        for (int i = 0; i < 4; i++)
            fbytes[n + i] = fcs[8*i +: 8];
        if (f.bad_fcs)
            fbytes[n] = fbytes[n] ^ 8'h01;
        n = n + 4;
    endtask

    task automatic drive_frame(input frame_entry_t f, input int n);
        byte_t b;
        for (int c = 0; c < f.npre + 1 + n; c++) begin
            if (c < f.npre)
                b = 8'h55;
            else if (c == f.npre)
                b = f.sfd;
            else
                b = fbytes[c - f.npre - 1];
            @(posedge RxClk);
            RxValid <= 1'b1;
            RxD     <= b;
            RxErr   <= f.err_en && (c == f.err_at);
        end
        @(posedge RxClk);
        RxValid <= 1'b0;
        RxD     <= '0;
        RxErr   <= 1'b0;
    endtask

    function automatic rx_status_t predict_status(input frame_entry_t f, input int n);
        rx_status_t s;
        s.nbytes       = frame_len_t'(n);
        s.first_byte   = fbytes[0];
        s.preamble_err = (f.npre != 4'd7) || (f.sfd != 8'hD5);  // Exactly 7, then D5
        s.rx_err       = f.err_en;
        s.crc_ok       = !f.bad_fcs;
        return s;
    endfunction

    // Pop the stored words of a frame, low byte first, odd tail padded
    task automatic pop_check(input int n);
        int    nwords;
        word_t exp;
        nwords = (n + 1) / 2;
        if (nwords > FIFO_WORDS)
            nwords = FIFO_WORDS;           // Rest was dropped
        for (int w = 0; w < nwords; w++) begin
            @(negedge RxClk);
            while (word_empty)
                @(negedge RxClk);
            exp[7:0]  = fbytes[2*w];
            exp[15:8] = (2*w + 1 < n) ? fbytes[2*w + 1] : 8'h00;
            check_word(w, exp, word_dout);
            @(posedge RxClk);
            word_rd <= 1'b1;
            @(posedge RxClk);
            word_rd <= 1'b0;
        end
        expect_empty("after the expected words were read");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        frame_entry_t f;
        rx_status_t   exp_st;
        int           n;
        RxValid   = 1'b0;
        RxD       = '0;
        RxErr     = 1'b0;
        word_rd   = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wen   = 1'b0;
        reg_wdata = '0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        good_exp  = 0;
        bad_exp   = 0;
        drop_exp  = 0;
        lcg_state = 32'd76;                // Seed
        load_frames();
        rst_n = 1'b0;
        repeat (10) @(posedge RxClk);
        rst_n <= 1'b1;

        expect_empty("after reset");
        counters_check();
        errors += test_errs;
        $display("Test reset: %s", (test_errs == 0) ? "pass" : "fail");

        for (int i = 0; i < NUM_FRAMES; i++) begin
            f         = frames[i];
            test_errs = 0;
            if (f.act == ACT_CLEAR) begin
                write_reg(RA_CLEAR);
                good_exp = 0;
                bad_exp  = 0;
                drop_exp = 0;
                counters_check();
            end else if (f.act == ACT_FLUSH) begin
                write_reg(RA_FLUSH);
                expect_empty("after a flush");
            end
            repeat (4) @(posedge RxClk);   // Inter-frame gap
            build_frame(f, n);
            drive_frame(f, n);
            exp_st = predict_status(f, n);
            @(negedge RxClk);
            while (!status_valid)
                @(negedge RxClk);
            check_status(exp_st, status);
            if ((n + 1) / 2 > FIFO_WORDS)
                drop_exp += (n + 1) / 2 - FIFO_WORDS;
            if (f.exp_good)
                good_exp++;
            else
                bad_exp++;
            // Words stay put when the next frame starts with a flush
            if (!(i + 1 < NUM_FRAMES && frames[i + 1].act == ACT_FLUSH))
                pop_check(n);
            counters_check();
            read_check(RA_LAST_STATUS, "last_status", reg_data_t'(exp_st));
            errors += test_errs;
            $display("Test %0d: %0d bytes, %s", i, n, (test_errs == 0) ? "pass" : "fail");
        end

        $display("Tests %0d, checks %0d, errors %0d", NUM_FRAMES + 1, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Cycle limit from frame, preamble and gap lengths
    initial begin
        int limit;
        int cycles;
        @(posedge rst_n);
        limit  = 500;
        cycles = 0;
        for (int i = 0; i < NUM_FRAMES; i++)
            limit += 2 * (frames[i].plen + 4 + frames[i].npre + 1 + 4);
        while (cycles < limit) begin
            @(posedge RxClk);
            cycles++;
        end
        $display("Run timed out after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- src/eth_rx_top.sv
// GMII receive top level
// Framer, word FIFO and status register block

`timescale 1ns/1ps

module eth_rx_top (
    input  logic                   RxClk,
    input  logic                   rst_n,
    // GMII receive
    input  logic                   RxValid,
    input  eth_rx_pkg::byte_t      RxD,
    input  logic                   RxErr,
    // Host word read
    input  logic                   word_rd,
    output eth_rx_pkg::word_t      word_dout,
    output logic                   word_empty,
    // Register bus
    input  eth_reg_pkg::reg_addr_t reg_raddr,
    input  eth_reg_pkg::reg_addr_t reg_waddr,
    input  logic                   reg_wen,
    input  eth_reg_pkg::reg_data_t reg_wdata,
    output eth_reg_pkg::reg_data_t reg_rdata,
    // Per-frame status
    output eth_rx_pkg::rx_status_t status,
    output logic                   status_valid
);
    import eth_rx_pkg::*;

    byte_t byte_data;   // Framer to packer
    logic  byte_wr;
    logic  frame_end;
    logic  flush;       // Register block to FIFO
    logic  word_drop;   // FIFO to drop counter

    gmii_rx_framer u_framer (
        .RxClk        (RxClk),
        .rst_n        (rst_n),
        .RxValid      (RxValid),
        .RxD          (RxD),
        .RxErr        (RxErr),
        .byte_data    (byte_data),
        .byte_wr      (byte_wr),
        .frame_end    (frame_end),
        .status       (status),
        .status_valid (status_valid)
    );

    rx_word_fifo u_fifo (
        .RxClk      (RxClk),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_wr    (byte_wr),
        .frame_end  (frame_end),
        .flush      (flush),
        .word_rd    (word_rd),
        .word_dout  (word_dout),
        .word_empty (word_empty),
        .word_drop  (word_drop)
    );

    rx_status_regs u_regs (
        .RxClk        (RxClk),
        .rst_n        (rst_n),
        .status       (status),
        .status_valid (status_valid),
        .word_drop    (word_drop),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wen      (reg_wen),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .flush        (flush)
    );

endmodule

//--- src/rx_status_regs.sv
// Receive status register block
// Good, bad and drop counters, last status record,
// readback mux and flush / clear write strobes

`timescale 1ns/1ps

module rx_status_regs (
    input  logic                   RxClk,
    input  logic                   rst_n,
    input  eth_rx_pkg::rx_status_t status,        // Record of finished frame
    input  logic                   status_valid,
    input  logic                   word_drop,     // Word lost in FIFO
    input  eth_reg_pkg::reg_addr_t reg_raddr,
    input  eth_reg_pkg::reg_addr_t reg_waddr,
    input  logic                   reg_wen,
    input  eth_reg_pkg::reg_data_t reg_wdata,
    output eth_reg_pkg::reg_data_t reg_rdata,
    output logic                   flush          // FIFO flush pulse
);
    import eth_rx_pkg::*;
    import eth_reg_pkg::*;

    cnt_t       good_cnt_q;
    cnt_t       bad_cnt_q;
    cnt_t       drop_cnt_q;
    rx_status_t last_status_q;
    logic       wr_hit;       // Qualified register write
    logic       clear;
    logic       frame_good;

    assign wr_hit     = reg_wen && reg_wdata[0];   // Bit 0 must be set
    assign clear      = wr_hit && (reg_waddr == RA_CLEAR);
    assign frame_good = status.crc_ok && !status.preamble_err && !status.rx_err;

    // --------------------------------------------------
    // Counters and holding register
    // --------------------------------------------------
    always_ff @(posedge RxClk or negedge rst_n) begin
        if (!rst_n) begin
            good_cnt_q    <= '0;
            bad_cnt_q     <= '0;
            drop_cnt_q    <= '0;
            last_status_q <= '0;
            flush         <= 1'b0;
        end else begin
            flush <= wr_hit && (reg_waddr == RA_FLUSH);
            if (status_valid)
                last_status_q <= status;
            if (clear) begin
                // Clear wins over a same-cycle event
                good_cnt_q <= '0;
                bad_cnt_q  <= '0;
                drop_cnt_q <= '0;
            end else begin
                if (status_valid && frame_good)
                    good_cnt_q <= good_cnt_q + 1'b1;
                if (status_valid && !frame_good)
                    bad_cnt_q <= bad_cnt_q + 1'b1;
                if (word_drop)
                    drop_cnt_q <= drop_cnt_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Readback, zero-extended
    // --------------------------------------------------
    always_comb begin
        case (reg_raddr)
            RA_GOOD_CNT:    reg_rdata = reg_data_t'(good_cnt_q);
            RA_BAD_CNT:     reg_rdata = reg_data_t'(bad_cnt_q);
            RA_LAST_STATUS: reg_rdata = reg_data_t'(last_status_q);
            RA_DROP_CNT:    reg_rdata = reg_data_t'(drop_cnt_q);
            default:        reg_rdata = '0;        // Unmapped
        endcase
    end

endmodule

//--- src/rx_word_fifo.sv
// Byte to word packer and word FIFO
// Low byte first, padded tail word at frame end,
// first-word fall-through read, overflow drop and flush

`timescale 1ns/1ps

module rx_word_fifo (
    input  logic              RxClk,
    input  logic              rst_n,
    input  eth_rx_pkg::byte_t byte_data,   // Frame byte
    input  logic              byte_wr,     // Frame byte strobe
    input  logic              frame_end,   // Flush odd byte as padded word
    input  logic              flush,       // Empty the FIFO
    input  logic              word_rd,     // Pop head word
    output eth_rx_pkg::word_t word_dout,   // Head word
    output logic              word_empty,
    output logic              word_drop    // Word lost, FIFO full
);
    import eth_rx_pkg::*;

    word_t     mem [WORD_FIFO_DEPTH];
    byte_t     pend_q;      // Low byte waiting for its partner
    logic      pend_vld_q;
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t count_q;
    logic      wr_req;      // Packer has a word
    word_t     wr_word;
    logic      full;
    logic      wr_ok;
    logic      rd_ok;

    // --------------------------------------------------
    // Packer
    // --------------------------------------------------
    always_comb begin
        wr_req  = 1'b0;
        wr_word = {byte_data, pend_q};              // Second byte goes high
        if (byte_wr && pend_vld_q) begin
            wr_req = 1'b1;
        end else if (frame_end && pend_vld_q) begin
            wr_req  = 1'b1;
            wr_word = {8'h00, pend_q};              // Odd tail, zero high half
        end
    end

    assign full       = (count_q == fifo_cnt_t'(WORD_FIFO_DEPTH));
    assign word_empty = (count_q == '0);
    assign wr_ok      = wr_req && !full;
    assign rd_ok      = word_rd && !word_empty;     // Pop on empty is ignored
    assign word_dout  = mem[rd_ptr_q];              // Fall-through head

    // --------------------------------------------------
    // Pointers, level and drop strobe
    // --------------------------------------------------
    always_ff @(posedge RxClk or negedge rst_n) begin
        if (!rst_n) begin
            pend_vld_q <= 1'b0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            word_drop  <= 1'b0;
        end else if (flush) begin
            pend_vld_q <= 1'b0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            word_drop  <= 1'b0;
        end else begin
            word_drop <= wr_req && full;
            if (byte_wr)
                pend_vld_q <= !pend_vld_q;
            else if (frame_end)
                pend_vld_q <= 1'b0;
            if (wr_ok)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_ok)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage and pending byte
    always_ff @(posedge RxClk) begin
        if (byte_wr && !pend_vld_q)
            pend_q <= byte_data;
        if (wr_ok)
            mem[wr_ptr_q] <= wr_word;
    end

    // Host never pops an empty FIFO
    a_no_read_empty: assert property (@(posedge RxClk) disable iff (!rst_n)
        word_rd |-> !word_empty);

endmodule

//--- src/gmii_rx_framer.sv
// GMII receive framer
// Preamble and SFD check, byte counter, CRC accumulator,
// frame byte strobes and end-of-frame status record

`timescale 1ns/1ps

module gmii_rx_framer (
    input  logic                   RxClk,
    input  logic                   rst_n,
    input  logic                   RxValid,       // GMII data valid
    input  eth_rx_pkg::byte_t      RxD,           // GMII data
    input  logic                   RxErr,         // GMII error
    output eth_rx_pkg::byte_t      byte_data,     // Frame byte after SFD
    output logic                   byte_wr,       // One strobe per frame byte
    output logic                   frame_end,     // End of frame pulse
    output eth_rx_pkg::rx_status_t status,        // Status of finished frame
    output logic                   status_valid   // Status strobe
);
    import eth_rx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD
    } rx_state_e;

    rx_state_e  state_q;
    pre_cnt_t   pre_cnt_q;    // Saturating count of 0x55 bytes
    logic       end_q;        // Frame finished last edge
    logic       pre_err_q;
    logic       rx_err_q;     // Sticky RxErr
    frame_len_t nbytes_q;
    byte_t      first_q;
    frame_len_t wr_cnt_q;     // Byte strobes sent in this frame
    crc_t       crc_q;
    crc_t       crc_next;
    crc_t       crc_refl;     // Register in residue orientation
    logic       sfd_ok;
    logic       in_frame;
    logic       in_payload;

    crc32_byte u_crc (
        .crc_in  (crc_q),
        .data    (RxD),
        .crc_out (crc_next)
    );

    assign crc_refl   = {<<{crc_q}};
    assign in_frame   = (state_q != ST_IDLE);
    assign in_payload = (state_q == ST_PAYLOAD);
    // Exactly PREAMBLE_LEN preamble bytes before the SFD
    assign sfd_ok     = (RxD == SFD_BYTE) && (pre_cnt_q == pre_cnt_t'(PREAMBLE_LEN));

    assign frame_end    = end_q;
    assign status_valid = end_q;

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge RxClk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            pre_cnt_q <= '0;
            byte_wr   <= 1'b0;
            end_q     <= 1'b0;
            wr_cnt_q  <= '0;
        end else begin
            byte_wr <= 1'b0;
            end_q   <= 1'b0;
            if (end_q)
                wr_cnt_q <= '0;                 // Record already out
            else if (byte_wr)
                wr_cnt_q <= wr_cnt_q + 1'b1;
            if (RxValid) begin
                case (state_q)
                    ST_IDLE, ST_PREAMBLE: begin
                        if (RxD == PREAMBLE_BYTE) begin
                            state_q <= ST_PREAMBLE;
                            if (pre_cnt_q != PRE_CNT_MAX)
                                pre_cnt_q <= pre_cnt_q + 1'b1;
                        end else begin
                            state_q <= ST_PAYLOAD;  // SFD or stray byte ends preamble
                        end
                    end
                    ST_PAYLOAD: byte_wr <= 1'b1;
                    default:    state_q <= ST_IDLE;
                endcase
            end else if (in_frame) begin
                state_q   <= ST_IDLE;               // Close frame once RxValid falls
                pre_cnt_q <= '0;
                end_q     <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Frame data, count, CRC and status record
    // --------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (RxValid) begin
            rx_err_q <= in_frame ? (rx_err_q | RxErr) : RxErr;
            if (in_payload) begin
                byte_data <= RxD;
                crc_q     <= crc_next;
                nbytes_q  <= nbytes_q + 1'b1;
                if (nbytes_q == '0)
                    first_q <= RxD;
            end else if (RxD != PREAMBLE_BYTE) begin
                pre_err_q <= !sfd_ok;               // Start of payload
                crc_q     <= CRC_INIT;
                nbytes_q  <= '0;
                first_q   <= '0;
            end
        end else if (in_frame) begin
            // A frame that never left the preamble reports an empty record
            status.nbytes       <= in_payload ? nbytes_q : '0;
            status.first_byte   <= in_payload ? first_q : '0;
            status.preamble_err <= !in_payload || pre_err_q;
            status.rx_err       <= rx_err_q;
            status.crc_ok       <= in_payload && (crc_refl == CRC_RESIDUE);
        end
    end

    // Status record is a single-cycle strobe
    a_status_pulse: assert property (@(posedge RxClk) disable iff (!rst_n)
        status_valid |=> !status_valid);

    // Strobes of a frame match its payload length, none from preamble bytes
    a_byte_in_payload: assert property (@(posedge RxClk) disable iff (!rst_n)
        status_valid |-> (status.nbytes == wr_cnt_q));

endmodule

//--- src/crc32_byte.sv
// Byte-wide CRC-32 update step
// Reflected algorithm, eight bit steps unrolled, no state

`timescale 1ns/1ps

module crc32_byte (
    input  eth_rx_pkg::crc_t  crc_in,   // Current register value
    input  eth_rx_pkg::byte_t data,     // Byte in line order, LSB first
    output eth_rx_pkg::crc_t  crc_out   // Register after this byte
);
    import eth_rx_pkg::*;

    always_comb begin
        crc_t c;

        c = crc_in;
        // LSB of the byte goes first on the wire
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        crc_out = c;
    end

endmodule

//--- src/eth_reg_pkg.sv
// Register side definitions for the receive status block
// Address and data types, counter width and address map

package eth_reg_pkg;

    typedef logic [3:0]  reg_addr_t;  // Register address
    typedef logic [31:0] reg_data_t;  // Register data
    typedef logic [15:0] cnt_t;       // Frame and drop counters

    // --------------------------------------------------
    // Read map
    // --------------------------------------------------
    localparam reg_addr_t RA_GOOD_CNT    = 4'd0;  // Good frames
    localparam reg_addr_t RA_BAD_CNT     = 4'd1;  // CRC, preamble or RxErr failures
    localparam reg_addr_t RA_LAST_STATUS = 4'd2;  // Most recent status record
    localparam reg_addr_t RA_DROP_CNT    = 4'd3;  // Words lost to a full FIFO

    // --------------------------------------------------
    // Write map, bit 0 of write data must be set
    // --------------------------------------------------
    localparam reg_addr_t RA_FLUSH = 4'd1;  // Empty the word FIFO
    localparam reg_addr_t RA_CLEAR = 4'd2;  // Zero all counters

endpackage

//--- src/eth_rx_pkg.sv
// Receive path definitions for the GMII frame receiver
// Byte, word, length and CRC types, per-frame status record,
// line-code bytes, CRC constants and word FIFO sizing

package eth_rx_pkg;

    // --------------------------------------------------
    // Basic widths
    // --------------------------------------------------
    typedef logic [7:0]  byte_t;       // One GMII byte
    typedef logic [15:0] word_t;       // Host-side FIFO word
    typedef logic [11:0] frame_len_t;  // Bytes after SFD, FCS included
    typedef logic [31:0] crc_t;        // CRC-32 register
    typedef logic [3:0]  pre_cnt_t;    // Preamble byte counter

    // Per-frame status record, 23 bits
    typedef struct packed {
        frame_len_t nbytes;        // Byte count after SFD
        byte_t      first_byte;    // First byte after SFD
        logic       preamble_err;  // Bad preamble length or SFD
        logic       rx_err;        // RxErr seen during frame
        logic       crc_ok;        // CRC residue matched
    } rx_status_t;

    // --------------------------------------------------
    // Line code
    // --------------------------------------------------
    localparam byte_t       PREAMBLE_BYTE = 8'h55;
    localparam byte_t       SFD_BYTE      = 8'hD5;
    localparam int unsigned PREAMBLE_LEN  = 7;   // 0x55 bytes required before SFD
    localparam pre_cnt_t    PRE_CNT_MAX   = pre_cnt_t'(PREAMBLE_LEN + 1);  // Saturation

    // CRC-32, reflected form
    localparam crc_t CRC_POLY    = 32'hEDB88320;
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    // Residue over data plus FCS; register is bit-reversed before compare
    localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

    // --------------------------------------------------
    // Word FIFO
    // --------------------------------------------------
    localparam int unsigned WORD_FIFO_DEPTH = 256;
    localparam int unsigned WORD_FIFO_AW    = $clog2(WORD_FIFO_DEPTH);

    typedef logic [WORD_FIFO_AW-1:0] fifo_ptr_t;  // Read / write pointer
    typedef logic [WORD_FIFO_AW:0]   fifo_cnt_t;  // Fill level, 0..DEPTH

endpackage
